//--- files.f
+incdir+include
hw/fpu_lite_pkg.sv
hw/fpu_axil_slave.sv
hw/fp_decode.sv
hw/rv32f_reg_file.sv
hw/fp_execute.sv
hw/fp_result.sv
hw/fpu_lite_top.sv
testbench/fpu_lite_props.sv
testbench/fpu_lite_tb.sv

//--- Bender.yml
package:
  name: fpu_lite

sources:
  - include_dirs:
      - include
    files:
      - hw/fpu_lite_pkg.sv
      - hw/fpu_axil_slave.sv
      - hw/fp_decode.sv
      - hw/rv32f_reg_file.sv
      - hw/fp_execute.sv
      - hw/fp_result.sv
      - hw/fpu_lite_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/fpu_lite_props.sv
      - testbench/fpu_lite_tb.sv

//--- testbench/fpu_lite_tb.sv
/* fpu lite testbench, axi-lite host with lfsr stimulus
   and a register model checking loads, sign injection, min/max and fcsr */
`timescale 1ns/1ps
module fpu_lite_tb;
  import fpu_lite_pkg::*;
  // guard is already set once the slave is compiled in the same unit
  `undef FPU_LITE_REGMAP_SVH
  `include "fpu_lite_regmap.svh"

  localparam int clk_period = 20;
  localparam int n_sgnj = 40;
  localparam int n_mm = 48;
  // reads and writes per section, status polls included
  localparam int txn_count = 34 + 70 + (n_sgnj + 40) + (16 + n_mm * 8) + 50;

  // +0, -0, two quiet nans, two signaling nans
  localparam logic [31:0] special_vals [6] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000,
    32'hffc1_2345, 32'h7f80_0001, 32'hff81_2345
  };
  // first min/max pairs hit the zero and nan corners
  localparam logic [4:0] fixed_rs1 [8] = '{5'd0, 5'd1, 5'd2, 5'd4, 5'd2, 5'd7, 5'd0, 5'd5};
  localparam logic [4:0] fixed_rs2 [8] = '{5'd1, 5'd0, 5'd3, 5'd5, 5'd8, 5'd2, 5'd4, 5'd9};

  logic        frf_rf;
  logic        rst;
  logic        awvalid;
  logic        awready;
  logic [11:0] awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [11:0] araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  logic [31:0] lfsr_state = 32'd85424;
  logic [31:0] model_regs [32];
  logic [7:0]  model_fcsr;

  fpu_lite_top i_fpu_lite_top (.*);

  bind fpu_lite_top fpu_lite_props i_fpu_lite_props (.*);

  initial frf_rf = 1'b0;
  always #10 frf_rf = ~frf_rf;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic logic [11:0] freg_addr(input int idx);
    return addr_freg_base + 12'(idx * 4);
  endfunction

  // r-type op-fp word
  function automatic logic [31:0] fp_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, opcode_fp};
  endfunction

  function automatic logic is_any_nan(input logic [31:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  function automatic logic is_signaling(input logic [31:0] x);
    return is_any_nan(x) && !x[22];
  endfunction

  // magnitude from a, sign picked by funct3
  function automatic logic [31:0] ref_sgnj(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
    case (f3)
      3'd0: return {b[31], a[30:0]};
      3'd1: return {!b[31], a[30:0]};
      default: return {a[31] ^ b[31], a[30:0]};
    endcase
  endfunction

  // sign-magnitude mapped to an unsigned key, -0 lands just below +0
  function automatic logic [31:0] ref_minmax(input logic is_max, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] ka;
    logic [31:0] kb;
    if (is_any_nan(a) && is_any_nan(b)) return canonical_nan;
    if (is_any_nan(a)) return b;
    if (is_any_nan(b)) return a;
    ka = a[31] ? ~a : {1'b1, a[30:0]};
    kb = b[31] ? ~b : {1'b1, b[30:0]};
    if (is_max) return (ka > kb) ? a : b;
    return (ka < kb) ? a : b;
  endfunction

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at time %0t: %s is %08h, expected %08h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // called 2 ns after a rising edge, returns at the same phase
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int stall;
    stall = int'(rand_bits(2));
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge frf_rf);
    while (!(awready && wready)) @(negedge frf_rf);
    @(posedge frf_rf);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
    // bready low for a while, bvalid has to wait
    repeat (stall) begin
      @(posedge frf_rf);
      #2;
    end
    bready = 1'b1;
    @(negedge frf_rf);
    while (!bvalid) @(negedge frf_rf);
    expect_word("bresp", {30'd0, bresp}, {30'd0, exp_resp});
    @(posedge frf_rf);
    #2;
    bready = 1'b0;
  endtask

  // one write per cycle while bready stays high
  // a response still held is released before the next write goes in
  task automatic stream_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge frf_rf);
    while (!(awready && wready)) begin
      @(posedge frf_rf);
      #2;
      bready = 1'b1;
      @(negedge frf_rf);
    end
    @(posedge frf_rf);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
    expect_word("bvalid", {31'd0, bvalid}, 32'd1);
    expect_word("bresp", {30'd0, bresp}, {30'd0, exp_resp});
  endtask

  task automatic axi_read(input logic [11:0] addr, input logic [1:0] exp_resp,
                          output logic [31:0] data);
    int stall;
    stall = int'(rand_bits(2));
    araddr = addr;
    arvalid = 1'b1;
    @(negedge frf_rf);
    while (!arready) @(negedge frf_rf);
    @(posedge frf_rf);
    #2;
    arvalid = 1'b0;
    repeat (stall) begin
      @(posedge frf_rf);
      #2;
    end
    rready = 1'b1;
    @(negedge frf_rf);
    while (!rvalid) @(negedge frf_rf);
    data = rdata;
    expect_word("rresp", {30'd0, rresp}, {30'd0, exp_resp});
    @(posedge frf_rf);
    #2;
    rready = 1'b0;
  endtask

  task automatic check_read(input logic [11:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] got;
    axi_read(addr, resp_okay, got);
    expect_word(name, got, exp);
  endtask

  task automatic check_regs();
    for (int i = 0; i < 32; i++) begin
      check_read(freg_addr(i), model_regs[i], $sformatf("f%0d", i));
    end
  endtask

  // poll status until nothing is in flight
  task automatic wait_idle();
    logic [31:0] status;
    status = 32'd1;
    while (status[status_busy]) axi_read(addr_status, resp_okay, status);
  endtask

  initial begin : watchdog
    #(txn_count * 200 * clk_period + 1000 * clk_period);
    $display("watchdog expired, the DUT stopped answering");
    $display("Test failed");
    $fatal(1, "timeout");
  end

  always @(negedge frf_rf) begin
    if (i_fpu_lite_top.i_fpu_lite_props.err_count != 0) begin
      $display("a bound protocol assertion failed at time %0t", $time);
      $display("Test failed");
      $fatal(1, "protocol check");
    end
  end

  initial begin : main
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        is_max;
    rst = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    repeat (5) @(posedge frf_rf);
    #2;
    rst = 1'b0;

    // reset contents
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = canonical_nan;
    end
    model_fcsr = '0;
    check_regs();
    check_read(addr_fcsr, 32'd0, "fcsr");
    check_read(addr_status, 32'd0, "status");

    // random loads, then holes in the map
    for (int i = 0; i < 32; i++) begin
      v = rand_bits(32);
      axi_write(freg_addr(i), v, resp_okay);
      model_regs[i] = v;
    end
    axi_write(12'h08c, rand_bits(32), resp_slverr);
    axi_write(12'h0fc, rand_bits(32), resp_slverr);
    // inside the register range but not word aligned
    axi_write(12'h006, rand_bits(32), resp_slverr);
    axi_write(addr_status, 32'hffff_ffff, resp_okay);
    wait_idle();
    check_regs();
    check_read(addr_status, 32'd0, "status");
    axi_read(12'h100, resp_slverr, v);

    // dependent sign-injection chain, one word per cycle so each source is bypassed
    rd = 5'(rand_bits(5));
    for (int k = 0; k < n_sgnj; k++) begin
      rs1 = rd;
      rs2 = 5'(rand_bits(5));
      rd = 5'(rand_bits(5));
      f3 = 3'(rand_bits(2) % 3);
      stream_write(addr_instr, fp_word(funct7_sgnj, f3, rd, rs1, rs2), resp_okay);
      model_regs[rd] = ref_sgnj(f3, model_regs[rs1], model_regs[rs2]);
    end
    // last response taken at the next edge
    @(posedge frf_rf);
    #2;
    bready = 1'b0;
    // last word still two edges from the register file
    axi_read(addr_status, resp_okay, v);
    expect_word("status busy", {31'd0, v[status_busy]}, 32'd1);
    wait_idle();
    check_regs();

    // min/max sources in f0..f15, results in f16..f31
    for (int i = 0; i < 16; i++) begin
      v = (i < 6) ? special_vals[i] : rand_bits(32);
      axi_write(freg_addr(i), v, resp_okay);
      model_regs[i] = v;
    end
    for (int k = 0; k < n_mm; k++) begin
      if (k < 8) begin
        rs1 = fixed_rs1[k];
        rs2 = fixed_rs2[k];
        is_max = k[0];
      end else begin
        rs1 = 5'(rand_bits(4));
        rs2 = 5'(rand_bits(4));
        is_max = rand_bits(1) != 32'd0;
      end
      rd = 5'(16 + rand_bits(4));
      a = model_regs[rs1];
      b = model_regs[rs2];
      axi_write(addr_instr, fp_word(funct7_minmax, is_max ? funct3_max : funct3_min,
                                    rd, rs1, rs2), resp_okay);
      model_regs[rd] = ref_minmax(is_max, a, b);
      // NV is flags bit 4
      model_fcsr[4] = model_fcsr[4] | is_signaling(a) | is_signaling(b);
      wait_idle();
      check_read(freg_addr(rd), model_regs[rd], $sformatf("f%0d", rd));
      check_read(addr_fcsr, {24'd0, model_fcsr}, "fcsr");
      // start clean so a later quiet nan cannot hide behind old NV
      if (model_fcsr != 8'd0) begin
        axi_write(addr_fcsr, 32'd0, resp_okay);
        model_fcsr = '0;
      end
    end

    // fcsr write sets frm and replaces the flags
    axi_write(addr_fcsr, 32'h0000_00a5, resp_okay);
    model_fcsr = 8'ha5;
    check_read(addr_fcsr, 32'h0000_00a5, "fcsr");
    axi_write(addr_instr, fp_word(funct7_minmax, funct3_max, 5'd20, 5'd4, 5'd7), resp_okay);
    model_regs[20] = ref_minmax(1'b1, model_regs[4], model_regs[7]);
    model_fcsr[4] = 1'b1;
    wait_idle();
    check_read(addr_fcsr, {24'd0, model_fcsr}, "fcsr");

    // addi word, then reserved funct3 in the sign-injection group
    axi_write(addr_instr, 32'h0000_0293, resp_okay);
    axi_write(addr_instr, fp_word(funct7_sgnj, 3'b011, 5'd9, 5'd2, 5'd1), resp_okay);
    wait_idle();
    check_read(addr_status, 32'h0000_0002, "status");
    check_regs();
    check_read(addr_fcsr, {24'd0, model_fcsr}, "fcsr");

    if (i_fpu_lite_top.i_fpu_lite_props.err_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("a bound protocol assertion failed during the run");
      $display("Test failed");
      $fatal(1, "protocol check");
    end
  end

endmodule

//--- testbench/fpu_lite_props.sv
/* axi-lite handshake and pipeline reset checks
   bound into the fpu lite top */
`timescale 1ns/1ps
module fpu_lite_props (
  input logic        frf_rf,
  input logic        rst,
  input logic        awready,
  input logic        wready,
  input logic        bvalid,
  input logic        bready,
  input logic [1:0]  bresp,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic [1:0]  rresp,
  input logic        f_wen
);

  // bumped by every failing property, watched from the testbench
  int err_count = 0;

  // write response stays up with the same code until taken
  bresp_hold: assert property (@(posedge frf_rf) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else begin
    $error("bvalid dropped or bresp changed before bready");
    err_count++;
  end

  // read response stays up with the same data until taken
  rdata_hold: assert property (@(posedge frf_rf) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
  else begin
    $error("rvalid dropped or rdata changed before rready");
    err_count++;
  end

  // pending write response blocks the next write
  aw_blocked: assert property (@(posedge frf_rf) disable iff (rst)
    bvalid && !bready |-> !awready && !wready)
  else begin
    $error("awready high while bvalid pending");
    err_count++;
  end

  // nothing can retire before the pipe fills
  wen_quiet: assert property (@(posedge frf_rf)
    $fell(rst) |-> !f_wen [*3])
  else begin
    $error("f_wen high within 3 cycles of reset release");
    err_count++;
  end

endmodule

//--- hw/fpu_lite_top.sv
/* fpu lite top, axi-lite slave in front of
   a three stage sign-injection and min/max pipeline around the fp register file */
`timescale 1ns/1ps
module fpu_lite_top (
  input  logic                                 frf_rf,
  input  logic                                 rst,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [fpu_lite_pkg::axil_addr_w-1:0] awaddr,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [fpu_lite_pkg::axil_data_w-1:0] wdata,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic [1:0]                           bresp,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [fpu_lite_pkg::axil_addr_w-1:0] araddr,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [fpu_lite_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                           rresp
);
  import fpu_lite_pkg::*;

  fp_cmd_t     cmd;
  fp_dec_t     dec;
  fp_res_t     res;
  fp_res_t     wb;
  logic        fcsr_wen;
  logic [7:0]  fcsr_wdata;
  logic [7:0]  fcsr_rdata;
  logic [4:0]  host_raddr;
  logic [31:0] host_rdata;
  logic [4:0]  f_rs1;
  logic [4:0]  f_rs2;
  logic [31:0] f_rs1_data;
  logic [31:0] f_rs2_data;
  logic        f_wen;
  logic [4:0]  f_rd;
  logic [31:0] f_wdata;
  logic [4:0]  f_flags;
  logic        pipe_busy;
  logic        illegal_seen;

  // host side
  fpu_axil_slave i_fpu_axil_slave (.*);

  // decode, execute, result
  fp_decode i_fp_decode (.*);
  fp_execute i_fp_execute (.*);
  fp_result i_fp_result (
    .*,
    .dec_valid(dec.valid),
    .cmd_valid(cmd.valid)
  );

  // frm is kept for readback only
  rv32f_reg_file #(
    .num_regs(32)
  ) i_rv32f_reg_file (
    .*,
    .f_frm()
  );

endmodule

//--- hw/fp_result.sv
/* result stage, the single write port into the register file
   plus pipeline occupancy and sticky illegal-instruction tracking */
`timescale 1ns/1ps
module fp_result (
  input  logic                  frf_rf,
  input  logic                  rst,
  input  fpu_lite_pkg::fp_res_t res,
  input  logic                  dec_valid,
  input  logic                  cmd_valid,
  output fpu_lite_pkg::fp_res_t wb,
  output logic                  f_wen,
  output logic [4:0]            f_rd,
  output logic [31:0]           f_wdata,
  output logic [4:0]            f_flags,
  output logic                  pipe_busy,
  output logic                  illegal_seen
);
  import fpu_lite_pkg::*;

  // retiring record, write and flags only for a valid legal op
  always_comb begin
    wb = res;
    wb.wen = res.valid & res.wen;
    wb.flags = (res.valid & res.wen) ? res.flags : 5'd0;
  end

  assign f_wen = wb.wen;
  assign f_rd = wb.rd;
  assign f_wdata = wb.value;
  assign f_flags = wb.flags;

  // anything still in flight
  assign pipe_busy = cmd_valid | dec_valid | res.valid;

  // valid with wen low means an illegal word retired
  always_ff @(posedge frf_rf) begin
    if (rst) begin
      illegal_seen <= 1'b0;
    end else if (res.valid && !res.wen) begin
      illegal_seen <= 1'b1;
    end
  end

endmodule

//--- hw/fp_execute.sv
/* execute stage, operand read with write-back bypass
   sign injection, min/max with ieee nan rules, invalid flag */
`timescale 1ns/1ps
module fp_execute (
  input  logic                  frf_rf,
  input  logic                  rst,
  input  fpu_lite_pkg::fp_dec_t dec,
  output logic [4:0]            f_rs1,
  output logic [4:0]            f_rs2,
  input  logic [31:0]           f_rs1_data,
  input  logic [31:0]           f_rs2_data,
  input  fpu_lite_pkg::fp_res_t wb,
  output fpu_lite_pkg::fp_res_t res
);
  import fpu_lite_pkg::*;

  logic [31:0] a;
  logic [31:0] b;
  logic        a_lt_b;
  logic [31:0] value;
  logic [4:0]  flags;

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // quiet bit clear
  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  assign f_rs1 = dec.rs1;
  assign f_rs2 = dec.rs2;

  // value retiring this cycle has not reached the array yet
  assign a = (wb.wen && (wb.rd == dec.rs1)) ? wb.value : f_rs1_data;
  assign b = (wb.wen && (wb.rd == dec.rs2)) ? wb.value : f_rs2_data;

  // order for non-nan inputs, -0 sits below +0
  always_comb begin
    if (a[31] != b[31]) begin
      a_lt_b = a[31];
    end else if (a[31]) begin
      a_lt_b = a[30:0] > b[30:0];
    end else begin
      a_lt_b = a[30:0] < b[30:0];
    end
  end

  always_comb begin
    value = a;
    flags = '0;
    case (dec.op)
      op_load: value = dec.imm;
      op_sgnj: value = {b[31], a[30:0]};
      op_sgnjn: value = {~b[31], a[30:0]};
      op_sgnjx: value = {a[31] ^ b[31], a[30:0]};
      op_min, op_max: begin
        if (is_nan(a) && is_nan(b)) begin
          value = canonical_nan;
        end else if (is_nan(a)) begin
          value = b;
        end else if (is_nan(b)) begin
          value = a;
        end else if ((dec.op == op_min) == a_lt_b) begin
          value = a;
        end else begin
          value = b;
        end
        // quiet nans pass without NV
        flags[flag_nv] = is_snan(a) | is_snan(b);
      end
      default: value = a;
    endcase
  end

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= dec.valid;
    end
    // illegal ops retire without a write
    res.wen <= (dec.op != op_illegal);
    res.rd <= dec.rd;
    res.value <= value;
    res.flags <= flags;
  end

endmodule

//--- hw/rv32f_reg_file.sv
/* floating-point register file with fcsr
   two operand reads, one host read, one write port with flag accrual */
`timescale 1ns/1ps
module rv32f_reg_file #(
  parameter int num_regs = 32
) (
  input  logic        frf_rf,
  input  logic        rst,
  input  logic        f_wen,
  input  logic [4:0]  f_rd,
  input  logic [31:0] f_wdata,
  input  logic [4:0]  f_flags,
  input  logic [4:0]  f_rs1,
  input  logic [4:0]  f_rs2,
  output logic [31:0] f_rs1_data,
  output logic [31:0] f_rs2_data,
  input  logic [4:0]  host_raddr,
  output logic [31:0] host_rdata,
  input  logic        fcsr_wen,
  input  logic [7:0]  fcsr_wdata,
  output logic [7:0]  fcsr_rdata,
  output logic [2:0]  f_frm
);
  import fpu_lite_pkg::*;

  logic [31:0] regs [num_regs];
  // frm 7:5, NV DZ OF UF NX in 4:0
  logic [7:0]  fcsr;

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= canonical_nan;
      end
    end else if (f_wen && (f_rd < num_regs)) begin
      regs[f_rd] <= f_wdata;
    end
  end

  // host write wins over accrual in the same cycle
  always_ff @(posedge frf_rf) begin
    if (rst) begin
      fcsr <= '0;
    end else if (fcsr_wen) begin
      fcsr <= fcsr_wdata;
    end else if (f_wen) begin
      fcsr[4:0] <= fcsr[4:0] | f_flags;
    end
  end

  // indices past num_regs read as canonical nan
  assign f_rs1_data = (f_rs1 < num_regs) ? regs[f_rs1] : canonical_nan;
  assign f_rs2_data = (f_rs2 < num_regs) ? regs[f_rs2] : canonical_nan;
  assign host_rdata = (host_raddr < num_regs) ? regs[host_raddr] : canonical_nan;

  assign fcsr_rdata = fcsr;
  assign f_frm = fcsr[7:5];

endmodule

//--- hw/fp_decode.sv
/* decode stage, registers the host command
   and cracks op-fp words of the sign-injection and min/max group */
`timescale 1ns/1ps
module fp_decode (
  input  logic                  frf_rf,
  input  logic                  rst,
  input  fpu_lite_pkg::fp_cmd_t cmd,
  output fpu_lite_pkg::fp_dec_t dec
);
  import fpu_lite_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  fp_op_e     op;

  // r-type fields
  assign opcode = cmd.word[6:0];
  assign funct3 = cmd.word[14:12];
  assign funct7 = cmd.word[31:25];

  always_comb begin
    op = op_illegal;
    if (cmd.is_load) begin
      op = op_load;
    end else if ((opcode == opcode_fp) && (funct7 == funct7_sgnj)) begin
      case (funct3)
        funct3_sgnj: op = op_sgnj;
        funct3_sgnjn: op = op_sgnjn;
        funct3_sgnjx: op = op_sgnjx;
        default: op = op_illegal;
      endcase
    end else if ((opcode == opcode_fp) && (funct7 == funct7_minmax)) begin
      case (funct3)
        funct3_min: op = op_min;
        funct3_max: op = op_max;
        default: op = op_illegal;
      endcase
    end
  end

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= cmd.valid;
    end
    dec.op <= op;
    // loads name their target by address, not by the word
    dec.rd <= cmd.is_load ? cmd.load_rd : cmd.word[11:7];
    dec.rs1 <= cmd.word[19:15];
    dec.rs2 <= cmd.word[24:20];
    dec.imm <= cmd.word;
  end

endmodule

//--- hw/fpu_axil_slave.sv
/* axi-lite slave for the fpu lite block
   turns host writes into pipeline commands, serves register, fcsr and status reads */
`timescale 1ns/1ps
module fpu_axil_slave (
  input  logic                                 frf_rf,
  input  logic                                 rst,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [fpu_lite_pkg::axil_addr_w-1:0] awaddr,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [fpu_lite_pkg::axil_data_w-1:0] wdata,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic [1:0]                           bresp,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [fpu_lite_pkg::axil_addr_w-1:0] araddr,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [fpu_lite_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                           rresp,
  output fpu_lite_pkg::fp_cmd_t                cmd,
  output logic                                 fcsr_wen,
  output logic [7:0]                           fcsr_wdata,
  output logic [4:0]                           host_raddr,
  input  logic [31:0]                          host_rdata,
  input  logic [7:0]                           fcsr_rdata,
  input  logic                                 pipe_busy,
  input  logic                                 illegal_seen
);
  import fpu_lite_pkg::*;
  `include "fpu_lite_regmap.svh"

  logic                   wr_accept;
  logic                   wr_freg;
  logic                   wr_fcsr;
  logic                   wr_instr;
  logic                   wr_mapped;
  logic [axil_addr_w-1:0] wr_off;
  logic                   rd_accept;
  logic                   rd_freg;
  logic [axil_addr_w-1:0] rd_off;
  axil_state_e            rd_state;

  // address and data must arrive together, a held response blocks the next write
  assign wr_accept = awvalid & wvalid & (~bvalid | bready);
  assign awready = wr_accept;
  assign wready = wr_accept;

  // write address decode
  assign wr_off = awaddr - addr_freg_base;
  assign wr_freg = (awaddr[1:0] == 2'b00) && (awaddr >= addr_freg_base) &&
                   (awaddr <= addr_freg_last);
  assign wr_fcsr = (awaddr == addr_fcsr);
  assign wr_instr = (awaddr == addr_instr);
  // status counts as mapped, the write itself is dropped
  assign wr_mapped = wr_freg | wr_fcsr | wr_instr | (awaddr == addr_status);

  // fcsr bypasses the pipeline
  assign fcsr_wen = wr_accept & wr_fcsr;
  assign fcsr_wdata = wdata[7:0];

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge frf_rf) begin
    if (wr_accept) begin
      bresp <= wr_mapped ? resp_okay : resp_slverr;
    end
  end

  // one command per register load or instruction word
  always_ff @(posedge frf_rf) begin
    if (rst) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= wr_accept & (wr_freg | wr_instr);
    end
    if (wr_accept) begin
      cmd.is_load <= wr_freg;
      cmd.load_rd <= wr_off[6:2];
      cmd.word <= wdata;
    end
  end

  // read side, one outstanding response
  assign rd_accept = arvalid && (rd_state == idle);
  assign arready = rd_accept;
  assign rvalid = (rd_state == resp_pending);
  assign rd_off = araddr - addr_freg_base;
  assign host_raddr = rd_off[6:2];
  assign rd_freg = (araddr[1:0] == 2'b00) && (araddr >= addr_freg_base) &&
                   (araddr <= addr_freg_last);

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      rd_state <= idle;
    end else begin
      case (rd_state)
        idle: if (rd_accept) rd_state <= resp_pending;
        resp_pending: if (rready) rd_state <= idle;
        default: rd_state <= idle;
      endcase
    end
  end

  // data captured at acceptance, stays put while rvalid waits
  always_ff @(posedge frf_rf) begin
    if (rd_accept) begin
      rdata <= '0;
      rresp <= resp_okay;
      if (rd_freg) begin
        rdata <= host_rdata;
      end else if (araddr == addr_fcsr) begin
        rdata[7:0] <= fcsr_rdata;
      end else if (araddr == addr_status) begin
        rdata[status_busy] <= pipe_busy;
        rdata[status_illegal] <= illegal_seen;
      end else begin
        rresp <= resp_slverr;
      end
    end
  end

endmodule

//--- hw/fpu_lite_pkg.sv
/* fpu lite shared definitions
   encodings, op and axi-lite read state enums, pipeline stage records */
package fpu_lite_pkg;

  // axi-lite port widths
  localparam int axil_addr_w = 12;
  localparam int axil_data_w = 32;
  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // rv32f op-fp major opcode and the two funct7 groups handled here
  localparam logic [6:0] opcode_fp = 7'b1010011;
  localparam logic [6:0] funct7_sgnj = 7'b0010000;
  localparam logic [6:0] funct7_minmax = 7'b0010100;
  localparam logic [2:0] funct3_sgnj = 3'b000;
  localparam logic [2:0] funct3_sgnjn = 3'b001;
  localparam logic [2:0] funct3_sgnjx = 3'b010;
  localparam logic [2:0] funct3_min = 3'b000;
  localparam logic [2:0] funct3_max = 3'b001;

  // quiet nan, positive, zero payload
  localparam logic [31:0] canonical_nan = 32'h7fc00000;

  // flags are NV DZ OF UF NX, msb first
  localparam int flag_nv = 4;

  typedef enum logic [2:0] {
    op_load,
    op_sgnj,
    op_sgnjn,
    op_sgnjx,
    op_min,
    op_max,
    op_illegal
  } fp_op_e;

  typedef enum logic {
    idle,
    resp_pending
  } axil_state_e;

  // slave to decode
  typedef struct packed {
    logic        valid;
    logic        is_load;
    logic [4:0]  load_rd;
    logic [31:0] word;
  } fp_cmd_t;

  // decode to execute
  typedef struct packed {
    logic        valid;
    fp_op_e      op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } fp_dec_t;

  // execute to result
  typedef struct packed {
    logic        valid;
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [4:0]  flags;
  } fp_res_t;

endpackage

//--- include/fpu_lite_regmap.svh
/* fpu lite host register map
   byte addresses of the words on the axi-lite port */
`ifndef FPU_LITE_REGMAP_SVH
`define FPU_LITE_REGMAP_SVH

// f0..f31, one word each
localparam logic [11:0] addr_freg_base = 12'h000;
localparam logic [11:0] addr_freg_last = 12'h07c;

// frm in 7:5, accrued flags in 4:0
localparam logic [11:0] addr_fcsr = 12'h080;

// writes here issue an instruction word
localparam logic [11:0] addr_instr = 12'h084;

// read only, writes are dropped
localparam logic [11:0] addr_status = 12'h088;
localparam int status_busy = 0;
localparam int status_illegal = 1;

`endif
